// ==== rvCfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// width of data words, addresses and the PC.
`define XLEN 32

// number of architectural integer registers.
`define REG_COUNT 32

// width of a register index field in the instruction word.
`define REG_ADDR_W 5

`endif

// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    // major opcodes of the RV32I subset handled by the slice.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // funct3 for OP and OP-IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// ==== pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOp_t;

    // what execute sends to writeback.
    typedef enum logic {
        RES_ALU,
        RES_PC_PLUS4
    } resultSrc_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branchKind_t;

    // operand A comes from the PC only for AUIPC.
    typedef enum logic {
        A_REG,
        A_PC
    } aSrc_t;

endpackage

// ==== regFile.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    input  logic                   wbEn,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`XLEN-1:0]       wbData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // x0 is hardwired, whatever the array holds.
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== decodeUnit.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module decodeUnit import rvIsaPkg::*, pipeCtrlPkg::*; (
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic                   wbEn,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`XLEN-1:0]       wbData,
    output logic                   validD,
    output logic                   regWriteD,
    output resultSrc_t             resultSrcD,
    output aluOp_t                 aluOpD,
    output logic                   aluBSrcImmD,
    output aSrc_t                  aSrcD,
    output branchKind_t            branchKindD,
    output logic [`XLEN-1:0]       rd1D,
    output logic [`XLEN-1:0]       rd2D,
    output logic [`XLEN-1:0]       pcD,
    output logic [`REG_ADDR_W-1:0] rs1D,
    output logic [`REG_ADDR_W-1:0] rs2D,
    output logic [`REG_ADDR_W-1:0] rdD,
    output logic [`XLEN-1:0]       extImmD,
    output logic [`XLEN-1:0]       pcPlus4D
);

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] immI, immU, immB, immJ;
    logic             supported, writes, usesRs1, usesRs2;

    // the alternate encoding means SUB only for register-register adds.
    function automatic aluOp_t aluFor(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            F3_ADD_SUB: aluFor = (alt && isReg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     aluFor = ALU_SLL;
            F3_SLT:     aluFor = ALU_SLT;
            F3_SLTU:    aluFor = ALU_SLTU;
            F3_XOR:     aluFor = ALU_XOR;
            F3_SRL_SRA: aluFor = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      aluFor = ALU_OR;
            default:    aluFor = ALU_AND;
        endcase
    endfunction

    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdD     = instr[11:7];

    assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign immU = {{(`XLEN-31){instr[31]}}, instr[30:12], 12'b0};
    assign immB = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        supported   = 1'b0;
        writes      = 1'b0;
        usesRs1     = 1'b0;
        usesRs2     = 1'b0;
        resultSrcD  = RES_ALU;
        aluOpD      = ALU_ADD;
        aluBSrcImmD = 1'b0;
        aSrcD       = A_REG;
        branchKindD = BR_NONE;
        extImmD     = immI;
        case (instr[6:0])
            OPC_OP: begin
                supported = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT &&
                            (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                writes    = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                aluOpD    = aluFor(funct3, funct7 == FUNCT7_ALT, 1'b1);
            end
            OPC_OP_IMM: begin
                // only the shifts put a funct7 in the immediate field.
                supported   = (funct3 != F3_SLL && funct3 != F3_SRL_SRA) ||
                              funct7 == FUNCT7_BASE ||
                              (funct7 == FUNCT7_ALT && funct3 == F3_SRL_SRA);
                writes      = 1'b1;
                usesRs1     = 1'b1;
                aluBSrcImmD = 1'b1;
                aluOpD      = aluFor(funct3, funct7 == FUNCT7_ALT, 1'b0);
            end
            OPC_LUI: begin
                supported   = 1'b1;
                writes      = 1'b1;
                aluOpD      = ALU_PASSB;
                aluBSrcImmD = 1'b1;
                extImmD     = immU;
            end
            OPC_AUIPC: begin
                supported   = 1'b1;
                writes      = 1'b1;
                aSrcD       = A_PC;
                aluBSrcImmD = 1'b1;
                extImmD     = immU;
            end
            OPC_JAL: begin
                supported   = 1'b1;
                writes      = 1'b1;
                resultSrcD  = RES_PC_PLUS4;
                branchKindD = BR_JAL;
                extImmD     = immJ;
            end
            OPC_JALR: begin
                supported   = (funct3 == 3'b000);
                writes      = 1'b1;
                usesRs1     = 1'b1;
                resultSrcD  = RES_PC_PLUS4;
                branchKindD = BR_JALR;
                aluBSrcImmD = 1'b1;
            end
            OPC_BRANCH: begin
                supported = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                extImmD   = immB;
                case (funct3)
                    F3_BEQ:  branchKindD = BR_BEQ;
                    F3_BNE:  branchKindD = BR_BNE;
                    F3_BLT:  branchKindD = BR_BLT;
                    F3_BGE:  branchKindD = BR_BGE;
                    F3_BLTU: branchKindD = BR_BLTU;
                    F3_BGEU: branchKindD = BR_BGEU;
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    assign validD    = instrValid && supported;
    assign regWriteD = validD && writes;

    // source indices that an instruction does not read are reported as x0.
    assign rs1D = usesRs1 ? rs1Addr : '0;
    assign rs2D = usesRs2 ? rs2Addr : '0;

    // the instruction in execute writes back this cycle, so take its result directly.
    assign rd1D = (wbEn && wbAddr == rs1Addr && rs1Addr != '0) ? wbData : rs1Data;
    assign rd2D = (wbEn && wbAddr == rs2Addr && rs2Addr != '0) ? wbData : rs2Data;

    assign pcD      = pc;
    assign pcPlus4D = pc + `XLEN'(4);

endmodule

// ==== idExReg.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module idExReg import pipeCtrlPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  logic                   flush,
    input  logic                   validD,
    input  logic                   regWriteD,
    input  resultSrc_t             resultSrcD,
    input  aluOp_t                 aluOpD,
    input  logic                   aluBSrcImmD,
    input  aSrc_t                  aSrcD,
    input  branchKind_t            branchKindD,
    input  logic [`XLEN-1:0]       rd1D,
    input  logic [`XLEN-1:0]       rd2D,
    input  logic [`XLEN-1:0]       pcD,
    input  logic [`REG_ADDR_W-1:0] rs1D,
    input  logic [`REG_ADDR_W-1:0] rs2D,
    input  logic [`REG_ADDR_W-1:0] rdD,
    input  logic [`XLEN-1:0]       extImmD,
    input  logic [`XLEN-1:0]       pcPlus4D,
    output logic                   validE,
    output logic                   regWriteE,
    output resultSrc_t             resultSrcE,
    output aluOp_t                 aluOpE,
    output logic                   aluBSrcImmE,
    output aSrc_t                  aSrcE,
    output branchKind_t            branchKindE,
    output logic [`XLEN-1:0]       rd1E,
    output logic [`XLEN-1:0]       rd2E,
    output logic [`XLEN-1:0]       pcE,
    output logic [`REG_ADDR_W-1:0] rs1E,
    output logic [`REG_ADDR_W-1:0] rs2E,
    output logic [`REG_ADDR_W-1:0] rdE,
    output logic [`XLEN-1:0]       extImmE,
    output logic [`XLEN-1:0]       pcPlus4E
);

    always_ff @(posedge clk) begin
        if (reset) begin
            validE      <= 1'b0;
            regWriteE   <= 1'b0;
            resultSrcE  <= RES_ALU;
            aluOpE      <= ALU_ADD;
            aluBSrcImmE <= 1'b0;
            aSrcE       <= A_REG;
            branchKindE <= BR_NONE;
            rd1E        <= '0;
            rd2E        <= '0;
            pcE         <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
            extImmE     <= '0;
            pcPlus4E    <= '0;
        end else if (flush) begin
            // a bubble only needs the fields that cause side effects cleared.
            validE      <= 1'b0;
            regWriteE   <= 1'b0;
            branchKindE <= BR_NONE;
        end else if (en) begin
            validE      <= validD;
            regWriteE   <= regWriteD;
            resultSrcE  <= resultSrcD;
            aluOpE      <= aluOpD;
            aluBSrcImmE <= aluBSrcImmD;
            aSrcE       <= aSrcD;
            branchKindE <= branchKindD;
            rd1E        <= rd1D;
            rd2E        <= rd2D;
            pcE         <= pcD;
            rs1E        <= rs1D;
            rs2E        <= rs2D;
            rdE         <= rdD;
            extImmE     <= extImmD;
            pcPlus4E    <= pcPlus4D;
        end
    end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module executeUnit import pipeCtrlPkg::*; (
    input  logic                   validE,
    input  logic                   regWriteE,
    input  resultSrc_t             resultSrcE,
    input  aluOp_t                 aluOpE,
    input  logic                   aluBSrcImmE,
    input  aSrc_t                  aSrcE,
    input  branchKind_t            branchKindE,
    input  logic [`XLEN-1:0]       rd1E,
    input  logic [`XLEN-1:0]       rd2E,
    input  logic [`XLEN-1:0]       pcE,
    input  logic [`REG_ADDR_W-1:0] rdE,
    input  logic [`XLEN-1:0]       extImmE,
    input  logic [`XLEN-1:0]       pcPlus4E,
    input  logic                   stall,
    output logic [`XLEN-1:0]       exResult,
    output logic                   exRegWrite,
    output logic                   exValid,
    output logic [`REG_ADDR_W-1:0] exRd,
    output logic                   wbEn,
    output logic [`REG_ADDR_W-1:0] wbAddr,
    output logic [`XLEN-1:0]       wbData,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirectPc
);

    localparam int ShamtW = $clog2(`XLEN);

    logic [`XLEN-1:0] srcA, srcB, aluOut;
    logic             taken;

    assign srcA = (aSrcE == A_PC) ? pcE : rd1E;
    assign srcB = aluBSrcImmE ? extImmE : rd2E;

    always_comb begin
        case (aluOpE)
            ALU_ADD:   aluOut = srcA + srcB;
            ALU_SUB:   aluOut = srcA - srcB;
            ALU_SLL:   aluOut = srcA << srcB[ShamtW-1:0];
            ALU_SLT:   aluOut = `XLEN'($signed(srcA) < $signed(srcB));
            ALU_SLTU:  aluOut = `XLEN'(srcA < srcB);
            ALU_XOR:   aluOut = srcA ^ srcB;
            ALU_SRL:   aluOut = srcA >> srcB[ShamtW-1:0];
            ALU_SRA:   aluOut = $signed(srcA) >>> srcB[ShamtW-1:0];
            ALU_OR:    aluOut = srcA | srcB;
            ALU_AND:   aluOut = srcA & srcB;
            ALU_PASSB: aluOut = srcB;
            default:   aluOut = '0;
        endcase
    end

    // branches compare the register operands, never the immediate.
    always_comb begin
        case (branchKindE)
            BR_BEQ:  taken = (rd1E == rd2E);
            BR_BNE:  taken = (rd1E != rd2E);
            BR_BLT:  taken = ($signed(rd1E) < $signed(rd2E));
            BR_BGE:  taken = ($signed(rd1E) >= $signed(rd2E));
            BR_BLTU: taken = (rd1E < rd2E);
            BR_BGEU: taken = (rd1E >= rd2E);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // a redirect only fires in a cycle where the stage advances, so a held
    // branch or jump leaves execute exactly once.
    assign redirect   = validE && taken && !stall;
    assign redirectPc = (branchKindE == BR_JALR) ? {aluOut[`XLEN-1:1], 1'b0} : pcE + extImmE;

    assign exResult   = (resultSrcE == RES_PC_PLUS4) ? pcPlus4E : aluOut;
    assign exValid    = validE;
    assign exRegWrite = validE && regWriteE;
    assign exRd       = rdE;

    assign wbEn   = exRegWrite && !stall;
    assign wbAddr = rdE;
    assign wbData = exResult;

endmodule

// ==== coreSlice.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module coreSlice import pipeCtrlPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   stall,
    output logic                   exValid,
    output logic [`REG_ADDR_W-1:0] exRd,
    output logic [`XLEN-1:0]       exResult,
    output logic                   exRegWrite,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirectPc
);

    logic [`REG_ADDR_W-1:0] rs1Addr, rs2Addr;
    logic [`XLEN-1:0]       rs1Data, rs2Data;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;

    logic                   validD, regWriteD, aluBSrcImmD;
    resultSrc_t             resultSrcD;
    aluOp_t                 aluOpD;
    aSrc_t                  aSrcD;
    branchKind_t            branchKindD;
    logic [`XLEN-1:0]       rd1D, rd2D, pcD, extImmD, pcPlus4D;
    logic [`REG_ADDR_W-1:0] rs1D, rs2D, rdD;

    logic                   validE, regWriteE, aluBSrcImmE;
    resultSrc_t             resultSrcE;
    aluOp_t                 aluOpE;
    aSrc_t                  aSrcE;
    branchKind_t            branchKindE;
    logic [`XLEN-1:0]       rd1E, rd2E, pcE, extImmE, pcPlus4E;
    logic [`REG_ADDR_W-1:0] rdE;

    regFile u_regFile (.*);

    decodeUnit u_decodeUnit (.*);

    // source indices reach execute for a hazard unit; this slice forwards in decode.
    idExReg u_idExReg (
        .*,
        .en    (!stall),
        .flush (redirect),
        .rs1E  (),
        .rs2E  ()
    );

    executeUnit u_executeUnit (.*);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // reset drops shortly after the last reset edge, like any other driven input.
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// ==== coreSliceTb.sv ====
`timescale 1ns/1ns
`include "rvCfg.svh"

module coreSliceTb import rvIsaPkg::*; ();

    localparam int NumCycles   = 3000;
    localparam int EdgeLimitNs = 400;

    logic                   clk, reset, instrValid, stall;
    logic [31:0]            instr;
    logic [`XLEN-1:0]       pc;
    logic                   exValid, exRegWrite, redirect;
    logic [`REG_ADDR_W-1:0] exRd;
    logic [`XLEN-1:0]       exResult, redirectPc;

    // architectural registers and the instruction the model holds in execute.
    logic [31:0] archRegs [32];
    logic        eValid, eRegWrite, eTaken;
    logic [4:0]  eRd;
    logic [31:0] eResult, eTarget;

    // what the fetch side presents this cycle.
    logic        curValid, curStall, redirectPrev, edgeSeen;
    logic [31:0] curInstr, curPc, redirectTarget;
    int          errors, checks, retired, cycle;

    tbClock #(.PeriodNs(40), .ResetCycles(2)) u_tbClock (.clk(clk), .reset(reset));

    coreSlice u_coreSlice (.*);

    task automatic reportCounts();
        $display("cycles %0d, retired %0d, checks %0d, errors %0d",
                 cycle, retired, checks, errors);
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        reportCounts();
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task nextRise();
        edgeSeen = 1'b0;
        fork
            begin
                @(posedge clk);
                edgeSeen = 1'b1;
            end
            #(EdgeLimitNs);
        join_any
        disable fork;
        if (!edgeSeen) abortRun("the clock stopped, no rising edge arrived in time");
    endtask

    task automatic waitResetRelease();
        int n;
        n = 0;
        while (reset !== 1'b0 && n < 8) begin
            nextRise();
            n++;
        end
        if (reset !== 1'b0) abortRun("reset was still asserted after eight clock edges");
    endtask

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    return {31'b0, a < b};
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // reads see every older instruction already retired, which is what forwarding provides.
    task automatic executeModel(input logic [31:0] ins, input logic [31:0] at);
        logic [31:0] a, b, immI, immU, immB, immJ;
        a = archRegs[ins[19:15]];
        b = archRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immU = {ins[31:12], 12'b0};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        eValid = 1'b1;
        eRegWrite = 1'b1;
        eTaken = 1'b0;
        eRd = ins[11:7];
        eResult = at + 32'd4;
        eTarget = '0;
        case (ins[6:0])
            OPC_OP:     eResult = aluModel(ins[14:12], ins[30], a, b);
            OPC_OP_IMM: eResult = aluModel(ins[14:12], ins[30] && ins[14:12] == F3_SRL_SRA,
                                           a, immI);
            OPC_LUI:    eResult = immU;
            OPC_AUIPC:  eResult = at + immU;
            OPC_JAL: begin
                eTaken = 1'b1;
                eTarget = at + immJ;
            end
            OPC_JALR: begin
                eTaken = 1'b1;
                eTarget = (a + immI) & ~32'd1;
            end
            OPC_BRANCH: begin
                eRegWrite = 1'b0;
                eTaken = branchModel(ins[14:12], a, b);
                eTarget = at + immB;
            end
            default: begin
                eValid = 1'b0;
                eRegWrite = 1'b0;
            end
        endcase
    endtask

    function automatic logic [4:0] pickReg();
        if ($urandom_range(0, 4) != 0) return 5'($urandom_range(0, 3));
        return 5'($urandom_range(0, 31));
    endfunction

    task automatic makeInstr(output logic valid, output logic [31:0] ins);
        int          kind;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        logic [20:0] j;
        logic [12:0] b;
        logic [11:0] jalrImm;
        logic [2:0]  brF3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        kind = $urandom_range(0, 19);
        rd = pickReg();
        rs1 = pickReg();
        rs2 = pickReg();
        f3 = 3'($urandom_range(0, 7));
        r = $urandom;
        j = 21'(($urandom_range(0, 31) - 16) * 4);
        b = 13'(($urandom_range(0, 31) - 16) * 4);
        jalrImm = 12'($urandom_range(0, 63) - 32);
        valid = 1'b1;
        if (kind < 6) begin
            f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && r[31]) ? FUNCT7_ALT : FUNCT7_BASE;
            ins = {f7, rs2, rs1, f3, rd, OPC_OP};
        end else if (kind < 11) begin
            if (f3 == F3_SLL) r[31:25] = FUNCT7_BASE;
            if (f3 == F3_SRL_SRA) r[31:25] = r[0] ? FUNCT7_ALT : FUNCT7_BASE;
            ins = {r[31:20], rs1, f3, rd, OPC_OP_IMM};
        end else if (kind == 11) begin
            ins = {r[31:12], rd, OPC_LUI};
        end else if (kind == 12) begin
            ins = {r[31:12], rd, OPC_AUIPC};
        end else if (kind == 13) begin
            ins = {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
        end else if (kind == 14) begin
            ins = {jalrImm, rs1, 3'b000, rd, OPC_JALR};
        end else if (kind < 18) begin
            f3 = brF3[$urandom_range(0, 5)];
            ins = {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
        end else if (kind == 18) begin
            // a load, which the slice does not implement.
            ins = {r[31:7], 7'b0000011};
        end else begin
            valid = 1'b0;
            ins = r;
        end
    endtask

    task automatic driveNext();
        if (!curStall) begin
            if (redirectPrev)
                curPc = redirectTarget;
            else if (curValid)
                curPc = curPc + 32'd4;
            makeInstr(curValid, curInstr);
        end
        curStall = ($urandom_range(0, 5) == 0);
        instrValid = curValid;
        instr = curInstr;
        pc = curPc;
        stall = curStall;
    endtask

    task automatic checkOutputs();
        checkValue("exValid", exValid, eValid);
        checkValue("exRegWrite", exRegWrite, eValid && eRegWrite);
        checkValue("redirect", redirect, eValid && eTaken && !curStall);
        if (eValid && eRegWrite) begin
            checkValue("exRd", exRd, eRd);
            checkValue("exResult", exResult, eResult);
        end
        if (eValid && eTaken) checkValue("redirectPc", redirectPc, eTarget);
    endtask

    // the edge retires the execute instruction, then decode moves into execute.
    task automatic advanceModel();
        redirectPrev = 1'b0;
        if (!curStall) begin
            if (eValid) retired++;
            if (eValid && eRegWrite && eRd != 0) archRegs[eRd] = eResult;
            if (eValid && eTaken) begin
                redirectPrev = 1'b1;
                redirectTarget = eTarget;
            end
            if ((eValid && eTaken) || !curValid) begin
                eValid = 1'b0;
                eRegWrite = 1'b0;
                eTaken = 1'b0;
            end else begin
                executeModel(curInstr, curPc);
            end
        end
    endtask

    initial begin
        void'($urandom(31));
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        stall = 1'b0;
        for (int i = 0; i < 32; i++) begin
            archRegs[i] = '0;
        end
        eValid = 1'b0;
        eRegWrite = 1'b0;
        eTaken = 1'b0;
        eRd = '0;
        eResult = '0;
        eTarget = '0;
        curValid = 1'b0;
        curStall = 1'b0;
        curInstr = '0;
        curPc = '0;
        redirectPrev = 1'b0;
        redirectTarget = '0;
        errors = 0;
        checks = 0;
        retired = 0;
        cycle = 0;
        // the first edge applies reset, so the execute outputs are cleared while it is held.
        nextRise();
        #12;
        checkValue("exValid", exValid, 1'b0);
        checkValue("exRegWrite", exRegWrite, 1'b0);
        checkValue("redirect", redirect, 1'b0);
        waitResetRelease();
        for (cycle = 0; cycle < NumCycles; cycle++) begin
            #2;
            driveNext();
            #10;
            checkOutputs();
            nextRise();
            advanceModel();
        end
        reportCounts();
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
rvIsaPkg.sv
pipeCtrlPkg.sv
regFile.sv
decodeUnit.sv
idExReg.sv
executeUnit.sv
coreSlice.sv
tbClock.sv
coreSliceTb.sv

// ==== Bender.yml ====
package:
  name: core_slice

sources:
  - include_dirs:
      - .
    files:
      - rvIsaPkg.sv
      - pipeCtrlPkg.sv
      - regFile.sv
      - decodeUnit.sv
      - idExReg.sv
      - executeUnit.sv
      - coreSlice.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - coreSliceTb.sv
